// File: mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W (`AXI_DATA_W / 8)

// sram window, 1 KiB from the base
`define MEM_BASE  32'h8000_0000
`define MEM_WORDS 256
`define MEM_BYTES (`MEM_WORDS * (`AXI_DATA_W / 8))

// command queue
`define CMD_DEPTH 4

// seed of the sram latency lfsr, must be nonzero
`define LFSR_SEED 3'b001

`endif

// File: axi_pkg.sv
`include "mem_settings.svh"

package axi_pkg;

    // plain bus vectors
    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;
    typedef logic [`AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [1:0]             axi_resp_t;

    // response codes
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_DECERR = 2'b11;  // outside the sram window

    // width of one byte lane
    localparam int BYTE_W = 8;

endpackage

// File: mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

    // word index into the sram array
    typedef logic [$clog2(`MEM_WORDS)-1:0] mem_index_t;

    // delay count and lfsr value
    typedef logic [2:0] lat_t;

    typedef enum logic [1:0] {
        M_IDLE,
        M_READ,
        M_WRITE
    } master_state_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE
    } sram_state_e;

endpackage

// File: cmd_fifo.sv
`timescale 1ns/100ps
`include "mem_settings.svh"

module cmd_fifo
    import axi_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      push,
    input  logic      push_write,
    input  axi_addr_t push_addr,
    input  axi_data_t push_wdata,
    input  axi_strb_t push_wstrb,
    input  logic      pop,
    output logic      full,
    output logic      empty,
    output logic      head_write,
    output axi_addr_t head_addr,
    output axi_data_t head_wdata,
    output axi_strb_t head_wstrb
);

    localparam int PTR_W = $clog2(`CMD_DEPTH);
    localparam logic [PTR_W-1:0] LAST  = PTR_W'(`CMD_DEPTH - 1);
    localparam logic [PTR_W:0]   DEPTH = (PTR_W + 1)'(`CMD_DEPTH);

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    logic      write_q [`CMD_DEPTH];
    axi_addr_t addr_q  [`CMD_DEPTH];
    axi_data_t wdata_q [`CMD_DEPTH];
    axi_strb_t wstrb_q [`CMD_DEPTH];

    assign full    = (count == DEPTH);
    assign empty   = (count == '0);
    assign do_push = push && !full;   // strobe while full is lost
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            write_q[wr_ptr] <= push_write;
            addr_q[wr_ptr]  <= push_addr;
            wdata_q[wr_ptr] <= push_wdata;
            wstrb_q[wr_ptr] <= push_wstrb;
        end
    end

    assign head_write = write_q[rd_ptr];
    assign head_addr  = addr_q[rd_ptr];
    assign head_wdata = wdata_q[rd_ptr];
    assign head_wstrb = wstrb_q[rd_ptr];

    a_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("cmd_fifo: command strobed while full, dropped");
    a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("cmd_fifo: pop while empty");

endmodule

// File: axi_lite_master.sv
`timescale 1ns/100ps

module axi_lite_master
    import axi_pkg::*;
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      empty,
    input  logic      head_write,
    input  axi_addr_t head_addr,
    input  axi_data_t head_wdata,
    input  axi_strb_t head_wstrb,
    output logic      pop,
    output axi_addr_t araddr,
    output logic      arvalid,
    input  logic      arready,
    input  axi_data_t rdata,
    input  axi_resp_t rresp,
    input  logic      rvalid,
    output logic      rready,
    output axi_addr_t awaddr,
    output logic      awvalid,
    input  logic      awready,
    output axi_data_t wdata,
    output axi_strb_t wstrb,
    output logic      wvalid,
    input  logic      wready,
    input  axi_resp_t bresp,
    input  logic      bvalid,
    output logic      bready,
    output logic      rsp_valid,
    output axi_data_t rsp_rdata,
    output axi_resp_t rsp_resp
);

    master_state_e state;
    axi_addr_t     addr_q;
    axi_data_t     wdata_q;
    axi_strb_t     wstrb_q;
    logic          r_done;
    logic          b_done;

    assign pop    = (state == M_IDLE) && !empty;
    assign rready = (state == M_READ);
    assign bready = (state == M_WRITE);
    assign r_done = rvalid && rready;
    assign b_done = bvalid && bready;

    // one address register serves both AR and AW
    assign araddr = addr_q;
    assign awaddr = addr_q;
    assign wdata  = wdata_q;
    assign wstrb  = wstrb_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= M_IDLE;
            arvalid   <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= r_done || b_done;  // pulse the cycle after R/B
            case (state)
                M_IDLE: begin
                    if (!empty && head_write) begin
                        state   <= M_WRITE;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                    end else if (!empty) begin
                        state   <= M_READ;
                        arvalid <= 1'b1;
                    end
                end
                M_READ: begin
                    if (arready) arvalid <= 1'b0;
                    if (r_done) state <= M_IDLE;
                end
                M_WRITE: begin
                    if (awready) awvalid <= 1'b0;  // aw and w drop on their own
                    if (wready) wvalid <= 1'b0;
                    if (b_done) state <= M_IDLE;
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            addr_q  <= head_addr;
            wdata_q <= head_wdata;
            wstrb_q <= head_wstrb;
        end
        if (r_done) begin
            rsp_rdata <= rdata;
            rsp_resp  <= rresp;
        end else if (b_done) begin
            rsp_rdata <= '0;
            rsp_resp  <= bresp;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr));
    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr));
    a_w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));

endmodule

// File: sram.sv
`timescale 1ns/100ps
`include "mem_settings.svh"

module sram
    import axi_pkg::*;
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  axi_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output axi_data_t rdata,
    output axi_resp_t rresp,
    output logic      rvalid,
    input  logic      rready,
    input  axi_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  axi_data_t wdata,
    input  axi_strb_t wstrb,
    input  logic      wvalid,
    output logic      wready,
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready
);

    localparam axi_addr_t MEM_LAST = axi_addr_t'(`MEM_BASE + `MEM_BYTES - 1);

    sram_state_e state;
    lat_t        lfsr;
    lat_t        lat_q;
    lat_t        cnt;
    logic        ack;       // response is up
    logic        mem_go;    // access the array once the delay is over
    logic        rd_accept;
    logic        wr_accept;
    logic        win_in;
    axi_addr_t   addr_in;
    axi_addr_t   addr_q;
    axi_data_t   wdata_q;
    axi_strb_t   wstrb_q;
    axi_resp_t   resp_q;
    mem_index_t  idx;

    axi_data_t mem [`MEM_WORDS];

    // write only when aw and w come together and no read is pending
    assign arready = (state == S_IDLE);
    assign awready = (state == S_IDLE) && !arvalid && wvalid;
    assign wready  = (state == S_IDLE) && !arvalid && awvalid;

    assign rd_accept = arvalid && arready;
    assign wr_accept = awvalid && awready;
    assign addr_in   = rd_accept ? araddr : awaddr;
    assign win_in    = (addr_in >= `MEM_BASE) && (addr_in <= MEM_LAST);
    assign idx       = addr_q[$bits(mem_index_t)+1:2];
    assign mem_go    = !ack && (cnt == lat_q);

    assign rvalid = (state == S_READ) && ack;
    assign bvalid = (state == S_WRITE) && ack;
    assign rresp  = resp_q;
    assign bresp  = resp_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            lfsr  <= `LFSR_SEED;
            cnt   <= '0;
            ack   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};  // x^3 + x^2 + 1
                    cnt  <= '0;
                    ack  <= rd_accept || wr_accept ? !win_in : 1'b0;  // decerr at once
                    if (rd_accept) state <= S_READ;
                    else if (wr_accept) state <= S_WRITE;
                end
                S_READ, S_WRITE: begin
                    if ((rvalid && rready) || (bvalid && bready)) begin
                        state <= S_IDLE;
                        ack   <= 1'b0;
                    end else if (mem_go) begin
                        ack <= 1'b1;
                    end else if (!ack) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept || wr_accept) begin
            addr_q  <= addr_in;
            wdata_q <= wdata;
            wstrb_q <= wstrb;
            lat_q   <= lfsr;
            resp_q  <= win_in ? RESP_OKAY : RESP_DECERR;
            rdata   <= '0;
        end else if (state == S_READ && mem_go) begin
            rdata <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_WRITE && mem_go) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (wstrb_q[i]) mem[idx][BYTE_W*i +: BYTE_W] <= wdata_q[BYTE_W*i +: BYTE_W];
            end
        end
    end

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: mem_subsys.sv
`timescale 1ns/100ps

module mem_subsys
    import axi_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  logic      cmd_write,
    input  axi_addr_t cmd_addr,
    input  axi_data_t cmd_wdata,
    input  axi_strb_t cmd_wstrb,
    output logic      cmd_full,
    output logic      rsp_valid,
    output axi_data_t rsp_rdata,
    output axi_resp_t rsp_resp
);

    // queue head
    logic      fifo_empty;
    logic      pop;
    logic      head_write;
    axi_addr_t head_addr;
    axi_data_t head_wdata;
    axi_strb_t head_wstrb;

    // axi-lite bus
    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;
    axi_data_t rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;
    axi_addr_t awaddr;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;

    cmd_fifo i_cmd_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (cmd_valid),
        .push_write (cmd_write),
        .push_addr  (cmd_addr),
        .push_wdata (cmd_wdata),
        .push_wstrb (cmd_wstrb),
        .pop        (pop),
        .full       (cmd_full),
        .empty      (fifo_empty),
        .head_write (head_write),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .head_wstrb (head_wstrb)
    );

    axi_lite_master i_axi_lite_master (
        .clk        (clk),
        .rst_n      (rst_n),
        .empty      (fifo_empty),
        .head_write (head_write),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .head_wstrb (head_wstrb),
        .pop        (pop),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_resp   (rsp_resp)
    );

    sram i_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

// File: tb_mem_subsys.sv
`timescale 1ns/100ps

module tb_mem_subsys
    import axi_pkg::*;
();

    localparam int CLK_NS     = 40;
    localparam int RST_CYCLES = 16;
    localparam int IDLE_CHECK = 8;   // quiet cycles checked after reset

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    logic      cmd_write;
    axi_addr_t cmd_addr;
    axi_data_t cmd_wdata;
    axi_strb_t cmd_wstrb;
    logic      cmd_full;
    logic      rsp_valid;
    axi_data_t rsp_rdata;
    axi_resp_t rsp_resp;

    // commands from the pattern file
    logic      pat_write [$];
    axi_addr_t pat_addr  [$];
    axi_data_t pat_wdata [$];
    axi_strb_t pat_wstrb [$];
    axi_data_t pat_rdata [$];
    axi_resp_t pat_resp  [$];

    // expected responses, oldest first
    axi_addr_t exp_addr  [$];
    axi_data_t exp_rdata [$];
    axi_resp_t exp_resp  [$];

    logic [31:0] lcg_state;
    int          sent_count = 0;
    int          rsp_count = 0;
    bit          loaded = 1'b0;
    bit          burst_pass = 1'b0;
    bit          full_seen = 1'b0;

    mem_subsys i_mem_subsys (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_wstrb (cmd_wstrb),
        .cmd_full  (cmd_full),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_resp  (rsp_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic load_patterns();
        int         fd;
        int         n;
        string      line;
        logic [7:0] op;
        axi_addr_t  addr;
        axi_data_t  wdata;
        axi_strb_t  wstrb;
        axi_data_t  rdata;
        axi_resp_t  resp;
        fd = $fopen("mem_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open mem_patterns.txt");
            $display("TEST FAILED");
            $fatal(1, "no stimulus file");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, wstrb, rdata, resp);
                if (n != 6 || (op != "W" && op != "R")) begin
                    $display("malformed line in mem_patterns.txt: %s", line);
                    $display("TEST FAILED");
                    $fatal(1, "bad stimulus line");
                end
                pat_write.push_back(op == "W");
                pat_addr.push_back(addr);
                pat_wdata.push_back(wdata);
                pat_wstrb.push_back(wstrb);
                pat_rdata.push_back(rdata);
                pat_resp.push_back(resp);
            end
        end
        $fclose(fd);
    endtask

    // one strobe, only once the queue has room
    task automatic send_command(input int i);
        @(negedge clk);
        while (cmd_full) @(negedge clk);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_write <= pat_write[i];
        cmd_addr  <= pat_addr[i];
        cmd_wdata <= pat_wdata[i];
        cmd_wstrb <= pat_wstrb[i];
        exp_addr.push_back(pat_addr[i]);
        exp_rdata.push_back(pat_rdata[i]);
        exp_resp.push_back(pat_resp[i]);
        sent_count++;
        @(posedge clk);   // push happens here
        cmd_valid <= 1'b0;
    endtask

    always @(negedge clk) begin : check_response
        axi_addr_t addr;
        axi_data_t want_data;
        axi_resp_t want_resp;
        if (rst_n && burst_pass && cmd_full) full_seen = 1'b1;
        if (rst_n && rsp_valid) begin
            assert (exp_resp.size() > 0) else begin
                $display("a response arrived with no command outstanding");
                $display("TEST FAILED");
                $fatal(1, "unexpected response");
            end
            addr      = exp_addr.pop_front();
            want_data = exp_rdata.pop_front();
            want_resp = exp_resp.pop_front();
            assert (rsp_resp == want_resp) else
                stop_on_error($sformatf("response code %0d for address %h, expected %0d",
                                        rsp_resp, addr, want_resp));
            assert (rsp_rdata == want_data) else
                stop_on_error($sformatf("data %h for address %h, expected %h",
                                        rsp_rdata, addr, want_data));
            rsp_count++;
        end
    end

    initial begin : watchdog
        longint limit_ns;
        wait (loaded);
        // two passes over the file
        limit_ns = longint'(2 * pat_write.size() * 20 + RST_CYCLES + IDLE_CHECK) * CLK_NS;
        #(limit_ns);
        $display("timeout: not all responses arrived within %0d ns", limit_ns);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int pass;
        int i;
        int gap;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_addr  = '0;
        cmd_wdata = '0;
        cmd_wstrb = '0;
        lcg_state = 32'h4978_646d;
        load_patterns();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        repeat (IDLE_CHECK) begin
            @(negedge clk);
            assert (!cmd_full && !rsp_valid) else
                stop_on_error($sformatf("cmd_full=%b rsp_valid=%b with no commands",
                                        cmd_full, rsp_valid));
        end

        // pass 0 with random gaps, pass 1 back to back to fill the queue
        for (pass = 0; pass < 2; pass++) begin
            burst_pass = (pass == 1);
            for (i = 0; i < pat_write.size(); i++) begin
                send_command(i);
                lcg_state = lcg_next(lcg_state);
                gap = burst_pass ? 0 : int'(lcg_state[17:16]);
                repeat (gap) @(posedge clk);
            end
            wait (rsp_count == sent_count);
        end

        repeat (4) @(negedge clk);   // room for a stray response
        assert (full_seen) else
            stop_on_error("cmd_full never rose while commands came back to back");
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: mem_patterns.txt
# op addr wdata wstrb exp_rdata exp_resp, all hex; W is a write and R a read
# writes expect rdata 0; resp 0 is OKAY, 3 is DECERR
W 80000000 deadbeef f 00000000 0
R 80000000 00000000 0 deadbeef 0
# partial strobes over earlier words
W 80000010 11223344 f 00000000 0
W 80000010 aabbccdd 5 00000000 0
R 80000010 00000000 0 11bb33dd 0
W 80000014 01020304 f 00000000 0
W 80000014 f0e0d0c0 a 00000000 0
W 80000018 cafef00d f 00000000 0
W 80000018 12345678 8 00000000 0
R 80000014 00000000 0 f002d004 0
R 80000018 00000000 0 12fef00d 0
# outside the window, 80000400 would alias word 0
W 7ffffffc 55555555 f 00000000 3
R 7ffffffc 00000000 0 00000000 3
W 80000400 66666666 f 00000000 3
R 80000400 00000000 0 00000000 3
R 80000000 00000000 0 deadbeef 0
# distinct words, read back in another order
W 80000020 a5a50020 f 00000000 0
W 800003fc a5a503fc f 00000000 0
W 80000200 a5a50200 f 00000000 0
W 80000104 a5a50104 f 00000000 0
R 80000200 00000000 0 a5a50200 0
R 800003fc 00000000 0 a5a503fc 0
R 80000104 00000000 0 a5a50104 0
R 80000020 00000000 0 a5a50020 0

// File: project.f
+incdir+.
axi_pkg.sv
mem_pkg.sv
cmd_fifo.sv
axi_lite_master.sv
sram.sv
mem_subsys.sv
tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_mem_subsys -o sim_mem_subsys
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_mem_subsys)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
